/* mips_core.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_core #(
    parameter int IMEM_DEPTH = 256,
    parameter int DMEM_DEPTH = 256
) (
    input  wire                                  i_clk,
    input  wire                                  i_rst,
    input  wire                                  i_load_en,
    input  wire  [$clog2(IMEM_DEPTH)-1:0]        i_load_addr,
    input  wire  [mips_pkg::XLEN-1:0]            i_load_instr,
    output logic                                 o_wb_valid,
    output logic [mips_pkg::REG_ADDR_W-1:0]      o_wb_reg,
    output logic [mips_pkg::XLEN-1:0]            o_wb_data
);

    // Stage outputs
    logic [mips_pkg::XLEN-1:0]       fetch_instr;
    logic [mips_pkg::XLEN-1:0]       dec_rs_data;
    logic [mips_pkg::XLEN-1:0]       dec_rt_data;
    logic [mips_pkg::XLEN-1:0]       dec_imm_ext;
    logic [mips_pkg::REG_ADDR_W-1:0] dec_rs;
    logic [mips_pkg::REG_ADDR_W-1:0] dec_rt;
    logic [mips_pkg::REG_ADDR_W-1:0] dec_dest;
    logic                            dec_reg_write;
    logic                            dec_mem_to_reg;
    logic                            dec_mem_write;
    logic                            dec_alu_src;
    logic [mips_pkg::ALU_OP_W-1:0]   dec_alu_op;
    logic [1:0]                      fwd_a;
    logic [1:0]                      fwd_b;
    logic [mips_pkg::XLEN-1:0]       ex_alu_result;
    logic [mips_pkg::XLEN-1:0]       ex_store_data;
    logic [mips_pkg::XLEN-1:0]       mem_rdata;
    logic [mips_pkg::XLEN-1:0]       wb_data;

    // IF/ID
    mips_pkg::mips_instr_u           if_id_instr;

    // ID/EX
    logic [mips_pkg::XLEN-1:0]       id_ex_rs_data;
    logic [mips_pkg::XLEN-1:0]       id_ex_rt_data;
    logic [mips_pkg::XLEN-1:0]       id_ex_imm_ext;
    logic [mips_pkg::REG_ADDR_W-1:0] id_ex_rs;
    logic [mips_pkg::REG_ADDR_W-1:0] id_ex_rt;
    logic [mips_pkg::REG_ADDR_W-1:0] id_ex_dest;
    logic                            id_ex_reg_write;
    logic                            id_ex_mem_to_reg;
    logic                            id_ex_mem_write;
    logic                            id_ex_alu_src;
    logic [mips_pkg::ALU_OP_W-1:0]   id_ex_alu_op;

    // EX/MEM
    logic [mips_pkg::XLEN-1:0]       ex_mem_alu_result;
    logic [mips_pkg::XLEN-1:0]       ex_mem_store_data;
    logic [mips_pkg::REG_ADDR_W-1:0] ex_mem_dest;
    logic                            ex_mem_reg_write;
    logic                            ex_mem_mem_to_reg;
    logic                            ex_mem_mem_write;

    // MEM/WB
    logic [mips_pkg::XLEN-1:0]       mem_wb_load_data;
    logic [mips_pkg::XLEN-1:0]       mem_wb_alu_result;
    logic [mips_pkg::REG_ADDR_W-1:0] mem_wb_dest;
    logic                            mem_wb_reg_write;
    logic                            mem_wb_mem_to_reg;

    // ------------------------------------------------------------
    // Pipeline registers
    // ------------------------------------------------------------
    // Cleared fetch word decodes as a no-op
    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            if_id_instr       <= '0;
            id_ex_reg_write   <= 1'b0;
            id_ex_mem_to_reg  <= 1'b0;
            id_ex_mem_write   <= 1'b0;
            ex_mem_reg_write  <= 1'b0;
            ex_mem_mem_to_reg <= 1'b0;
            ex_mem_mem_write  <= 1'b0;
            mem_wb_reg_write  <= 1'b0;
            mem_wb_mem_to_reg <= 1'b0;
        end else begin
            if_id_instr       <= fetch_instr;
            id_ex_reg_write   <= dec_reg_write;
            id_ex_mem_to_reg  <= dec_mem_to_reg;
            id_ex_mem_write   <= dec_mem_write;
            ex_mem_reg_write  <= id_ex_reg_write;
            ex_mem_mem_to_reg <= id_ex_mem_to_reg;
            ex_mem_mem_write  <= id_ex_mem_write;
            mem_wb_reg_write  <= ex_mem_reg_write;
            mem_wb_mem_to_reg <= ex_mem_mem_to_reg;
        end
    end

    always_ff @(posedge i_clk) begin
        id_ex_rs_data     <= dec_rs_data;
        id_ex_rt_data     <= dec_rt_data;
        id_ex_imm_ext     <= dec_imm_ext;
        id_ex_rs          <= dec_rs;
        id_ex_rt          <= dec_rt;
        id_ex_dest        <= dec_dest;
        id_ex_alu_src     <= dec_alu_src;
        id_ex_alu_op      <= dec_alu_op;
        ex_mem_alu_result <= ex_alu_result;
        ex_mem_store_data <= ex_store_data;
        ex_mem_dest       <= id_ex_dest;
        mem_wb_load_data  <= mem_rdata;
        mem_wb_alu_result <= ex_mem_alu_result;
        mem_wb_dest       <= ex_mem_dest;
    end

    // ------------------------------------------------------------
    // Stages
    // ------------------------------------------------------------
    mips_fetch #(
        .IMEM_DEPTH (IMEM_DEPTH)
    ) u_fetch (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_load_en    (i_load_en),
        .i_load_addr  (i_load_addr),
        .i_load_instr (i_load_instr),
        .o_instr      (fetch_instr),
        .o_pc         ()
    );

    mips_decode u_decode (
        .i_clk        (i_clk),
        .i_instr      (if_id_instr),
        .i_wb_we      (mem_wb_reg_write),
        .i_wb_addr    (mem_wb_dest),
        .i_wb_data    (wb_data),
        .o_rs_data    (dec_rs_data),
        .o_rt_data    (dec_rt_data),
        .o_imm_ext    (dec_imm_ext),
        .o_rs         (dec_rs),
        .o_rt         (dec_rt),
        .o_dest       (dec_dest),
        .o_reg_write  (dec_reg_write),
        .o_mem_to_reg (dec_mem_to_reg),
        .o_mem_write  (dec_mem_write),
        .o_alu_src    (dec_alu_src),
        .o_alu_op     (dec_alu_op)
    );

    mips_forwarding u_forwarding (
        .i_ex_rs         (id_ex_rs),
        .i_ex_rt         (id_ex_rt),
        .i_mem_dest      (ex_mem_dest),
        .i_mem_reg_write (ex_mem_reg_write),
        .i_wb_dest       (mem_wb_dest),
        .i_wb_reg_write  (mem_wb_reg_write),
        .o_fwd_a         (fwd_a),
        .o_fwd_b         (fwd_b)
    );

    mips_execute u_execute (
        .i_rs_data    (id_ex_rs_data),
        .i_rt_data    (id_ex_rt_data),
        .i_imm_ext    (id_ex_imm_ext),
        .i_alu_src    (id_ex_alu_src),
        .i_alu_op     (id_ex_alu_op),
        .i_fwd_a      (fwd_a),
        .i_fwd_b      (fwd_b),
        .i_mem_result (ex_mem_alu_result),
        .i_wb_data    (wb_data),
        .o_alu_result (ex_alu_result),
        .o_store_data (ex_store_data)
    );

    mips_data_mem #(
        .DMEM_DEPTH (DMEM_DEPTH)
    ) u_data_mem (
        .i_clk   (i_clk),
        .i_we    (ex_mem_mem_write),
        .i_addr  (ex_mem_alu_result),
        .i_wdata (ex_mem_store_data),
        .o_rdata (mem_rdata)
    );

    // ------------------------------------------------------------
    // Write-back and retire trace
    // ------------------------------------------------------------
    assign wb_data    = mem_wb_mem_to_reg ? mem_wb_load_data : mem_wb_alu_result;
    // Writes to r0 are dropped by the register file, so keep them off the trace
    assign o_wb_valid = mem_wb_reg_write && (mem_wb_dest != '0);
    assign o_wb_reg   = mem_wb_dest;
    assign o_wb_data  = wb_data;

endmodule

`default_nettype wire

/* mips_data_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_data_mem #(
    parameter int DMEM_DEPTH = 256
) (
    input  wire                                  i_clk,
    input  wire                                  i_we,
    input  wire  [mips_pkg::XLEN-1:0]            i_addr,
    input  wire  [mips_pkg::XLEN-1:0]            i_wdata,
    output logic [mips_pkg::XLEN-1:0]            o_rdata
);

    localparam int IDX_W = $clog2(DMEM_DEPTH);

    logic [mips_pkg::XLEN-1:0] dmem [DMEM_DEPTH];
    logic [IDX_W-1:0]          word_idx;

    // Byte address in, word index out, low two bits ignored
    assign word_idx = i_addr[IDX_W+1:2];

    always_ff @(posedge i_clk) begin
        if (i_we) begin
            dmem[word_idx] <= i_wdata;
        end
    end

    assign o_rdata = dmem[word_idx];

endmodule

`default_nettype wire

/* mips_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_decode (
    input  wire                                  i_clk,
    input  wire  mips_pkg::mips_instr_u          i_instr,
    input  wire                                  i_wb_we,
    input  wire  [mips_pkg::REG_ADDR_W-1:0]      i_wb_addr,
    input  wire  [mips_pkg::XLEN-1:0]            i_wb_data,
    output logic [mips_pkg::XLEN-1:0]            o_rs_data,
    output logic [mips_pkg::XLEN-1:0]            o_rt_data,
    output logic [mips_pkg::XLEN-1:0]            o_imm_ext,
    output logic [mips_pkg::REG_ADDR_W-1:0]      o_rs,
    output logic [mips_pkg::REG_ADDR_W-1:0]      o_rt,
    output logic [mips_pkg::REG_ADDR_W-1:0]      o_dest,
    output logic                                 o_reg_write,
    output logic                                 o_mem_to_reg,
    output logic                                 o_mem_write,
    output logic                                 o_alu_src,
    output logic [mips_pkg::ALU_OP_W-1:0]        o_alu_op
);

    logic is_rtype;

    assign is_rtype = (i_instr.r.opcode == mips_pkg::OP_RTYPE);

    mips_reg_file u_reg_file (
        .i_clk      (i_clk),
        .i_rs_addr  (i_instr.r.rs),
        .i_rt_addr  (i_instr.r.rt),
        .i_we       (i_wb_we),
        .i_wr_addr  (i_wb_addr),
        .i_wr_data  (i_wb_data),
        .o_rs_data  (o_rs_data),
        .o_rt_data  (o_rt_data)
    );

    assign o_rs      = i_instr.r.rs;
    assign o_rt      = i_instr.r.rt;
    assign o_dest    = is_rtype ? i_instr.r.rd : i_instr.r.rt;
    assign o_imm_ext = {{(mips_pkg::XLEN-16){i_instr.i.imm[15]}}, i_instr.i.imm};

    // ------------------------------------------------------------
    // Control decode
    // ------------------------------------------------------------
    always_comb begin
        o_reg_write  = 1'b0;
        o_mem_to_reg = 1'b0;
        o_mem_write  = 1'b0;
        o_alu_src    = 1'b0;
        o_alu_op     = mips_pkg::ALU_ADD;
        case (i_instr.r.opcode)
            mips_pkg::OP_RTYPE: begin
                o_reg_write = 1'b1;
                case (i_instr.r.funct)
                    mips_pkg::FN_ADD: o_alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUB: o_alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND: o_alu_op = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:  o_alu_op = mips_pkg::ALU_OR;
                    mips_pkg::FN_SLT: o_alu_op = mips_pkg::ALU_SLT;
                    // Covers the all-zero no-op too
                    default:          o_reg_write = 1'b0;
                endcase
            end
            mips_pkg::OP_ADDI: begin
                o_reg_write = 1'b1;
                o_alu_src   = 1'b1;
            end
            mips_pkg::OP_LW: begin
                o_reg_write  = 1'b1;
                o_mem_to_reg = 1'b1;
                o_alu_src    = 1'b1;
            end
            mips_pkg::OP_SW: begin
                o_mem_write = 1'b1;
                o_alu_src   = 1'b1;
            end
            default: begin
                o_reg_write = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* mips_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_execute (
    input  wire  [mips_pkg::XLEN-1:0]            i_rs_data,
    input  wire  [mips_pkg::XLEN-1:0]            i_rt_data,
    input  wire  [mips_pkg::XLEN-1:0]            i_imm_ext,
    input  wire                                  i_alu_src,
    input  wire  [mips_pkg::ALU_OP_W-1:0]        i_alu_op,
    input  wire  [1:0]                           i_fwd_a,
    input  wire  [1:0]                           i_fwd_b,
    input  wire  [mips_pkg::XLEN-1:0]            i_mem_result,
    input  wire  [mips_pkg::XLEN-1:0]            i_wb_data,
    output logic [mips_pkg::XLEN-1:0]            o_alu_result,
    output logic [mips_pkg::XLEN-1:0]            o_store_data
);

    logic [mips_pkg::XLEN-1:0] op_a;
    logic [mips_pkg::XLEN-1:0] op_b_reg;
    logic [mips_pkg::XLEN-1:0] op_b;

    function automatic logic [mips_pkg::XLEN-1:0] fwd_mux(
        input logic [1:0]                sel,
        input logic [mips_pkg::XLEN-1:0] reg_val
    );
        case (sel)
            mips_pkg::FWD_MEM: fwd_mux = i_mem_result;
            mips_pkg::FWD_WB:  fwd_mux = i_wb_data;
            default:           fwd_mux = reg_val;
        endcase
    endfunction

    // ------------------------------------------------------------
    // Operand select
    // ------------------------------------------------------------
    assign op_a         = fwd_mux(i_fwd_a, i_rs_data);
    assign op_b_reg     = fwd_mux(i_fwd_b, i_rt_data);
    assign op_b         = i_alu_src ? i_imm_ext : op_b_reg;
    assign o_store_data = op_b_reg;

    // ------------------------------------------------------------
    // ALU
    // ------------------------------------------------------------
    always_comb begin
        case (i_alu_op)
            mips_pkg::ALU_SUB: o_alu_result = op_a - op_b;
            mips_pkg::ALU_AND: o_alu_result = op_a & op_b;
            mips_pkg::ALU_OR:  o_alu_result = op_a | op_b;
            mips_pkg::ALU_SLT: o_alu_result = {{(mips_pkg::XLEN-1){1'b0}},
                                               ($signed(op_a) < $signed(op_b))};
            default:           o_alu_result = op_a + op_b;
        endcase
    end

endmodule

`default_nettype wire

/* mips_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_fetch #(
    parameter int IMEM_DEPTH = 256
) (
    input  wire                               i_clk,
    input  wire                               i_rst,
    input  wire                               i_load_en,
    input  wire  [$clog2(IMEM_DEPTH)-1:0]     i_load_addr,
    input  wire  [mips_pkg::XLEN-1:0]         i_load_instr,
    output logic [mips_pkg::XLEN-1:0]         o_instr,
    output logic [mips_pkg::XLEN-1:0]         o_pc
);

    localparam int IDX_W = $clog2(IMEM_DEPTH);

    logic [mips_pkg::XLEN-1:0] imem [IMEM_DEPTH];
    logic [mips_pkg::XLEN-1:0] pc;

    // Program load port, only driven while the core sits in reset
    always_ff @(posedge i_clk) begin
        if (i_load_en) begin
            imem[i_load_addr] <= i_load_instr;
        end
    end

    // Sequential PC, one word per cycle
    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            pc <= '0;
        end else begin
            pc <= pc + mips_pkg::XLEN'(4);
        end
    end

    assign o_instr = imem[pc[IDX_W+1:2]];
    assign o_pc    = pc;

endmodule

`default_nettype wire

/* mips_forwarding.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_forwarding (
    input  wire  [mips_pkg::REG_ADDR_W-1:0]      i_ex_rs,
    input  wire  [mips_pkg::REG_ADDR_W-1:0]      i_ex_rt,
    input  wire  [mips_pkg::REG_ADDR_W-1:0]      i_mem_dest,
    input  wire                                  i_mem_reg_write,
    input  wire  [mips_pkg::REG_ADDR_W-1:0]      i_wb_dest,
    input  wire                                  i_wb_reg_write,
    output logic [1:0]                           o_fwd_a,
    output logic [1:0]                           o_fwd_b
);

    // Youngest producer wins, r0 is never forwarded
    function automatic logic [1:0] fwd_sel(input logic [mips_pkg::REG_ADDR_W-1:0] src);
        if (i_mem_reg_write && (i_mem_dest != '0) && (i_mem_dest == src)) begin
            fwd_sel = mips_pkg::FWD_MEM;
        end else if (i_wb_reg_write && (i_wb_dest != '0) && (i_wb_dest == src)) begin
            fwd_sel = mips_pkg::FWD_WB;
        end else begin
            fwd_sel = mips_pkg::FWD_NONE;
        end
    endfunction

    assign o_fwd_a = fwd_sel(i_ex_rs);
    assign o_fwd_b = fwd_sel(i_ex_rt);

endmodule

`default_nettype wire

/* mips_pkg.sv */
`default_nettype none

package mips_pkg;

    // ------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int ALU_OP_W   = 3;

    // Major opcodes
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;

    // Function codes of the register-type group
    localparam logic [5:0] FN_ADD = 6'h20;
    localparam logic [5:0] FN_SUB = 6'h22;
    localparam logic [5:0] FN_AND = 6'h24;
    localparam logic [5:0] FN_OR  = 6'h25;
    localparam logic [5:0] FN_SLT = 6'h2a;

    // ALU operations
    localparam logic [ALU_OP_W-1:0] ALU_ADD = 3'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB = 3'd1;
    localparam logic [ALU_OP_W-1:0] ALU_AND = 3'd2;
    localparam logic [ALU_OP_W-1:0] ALU_OR  = 3'd3;
    localparam logic [ALU_OP_W-1:0] ALU_SLT = 3'd4;

    // Operand source selects for the execute stage
    localparam logic [1:0] FWD_NONE = 2'd0;
    localparam logic [1:0] FWD_MEM  = 2'd1;
    localparam logic [1:0] FWD_WB   = 2'd2;

    // ------------------------------------------------------------
    // Instruction word, register and immediate views
    // ------------------------------------------------------------
    typedef union packed {
        struct packed {
            logic [5:0]            opcode;
            logic [REG_ADDR_W-1:0] rs;
            logic [REG_ADDR_W-1:0] rt;
            logic [REG_ADDR_W-1:0] rd;
            logic [4:0]            shamt;
            logic [5:0]            funct;
        } r;
        struct packed {
            logic [5:0]            opcode;
            logic [REG_ADDR_W-1:0] rs;
            logic [REG_ADDR_W-1:0] rt;
            logic [15:0]           imm;
        } i;
    } mips_instr_u;

endpackage

`default_nettype wire

/* mips_reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_reg_file (
    input  wire                                  i_clk,
    input  wire  [mips_pkg::REG_ADDR_W-1:0]      i_rs_addr,
    input  wire  [mips_pkg::REG_ADDR_W-1:0]      i_rt_addr,
    input  wire                                  i_we,
    input  wire  [mips_pkg::REG_ADDR_W-1:0]      i_wr_addr,
    input  wire  [mips_pkg::XLEN-1:0]            i_wr_data,
    output logic [mips_pkg::XLEN-1:0]            o_rs_data,
    output logic [mips_pkg::XLEN-1:0]            o_rt_data
);

    logic [mips_pkg::XLEN-1:0] regs [32];

    // r0 is hardwired, never stored
    always_ff @(posedge i_clk) begin
        if (i_we && (i_wr_addr != '0)) begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    // Write-through so decode sees the value retiring this cycle
    assign o_rs_data = (i_rs_addr == '0) ? '0 :
                       (i_we && (i_wr_addr == i_rs_addr)) ? i_wr_data : regs[i_rs_addr];
    assign o_rt_data = (i_rt_addr == '0) ? '0 :
                       (i_we && (i_wr_addr == i_rt_addr)) ? i_wr_data : regs[i_rt_addr];

endmodule

`default_nettype wire

/* mips_vectors.txt */
// All values hex: program length, program words, write count,
// then one expected write per line as register number and value
10
2001FFFD
20020005
0022182A
0041202A
00222820
20A50004
20A50008
00A23022
00253824
00224025
AC050010
8C090010
20000007
00000000
01205020
00035820
d
1 FFFFFFFD
2 00000005
3 00000001
4 00000000
5 00000002
5 00000006
5 0000000E
6 00000009
7 0000000C
8 FFFFFFFD
9 0000000E
a 0000000E
b 00000001

/* run.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_mips -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_mips)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    exit 1
fi

if echo "$output" | grep -qx "sim passed"; then
    exit 0
fi
exit 1

/* tb.f */
mips_pkg.sv
mips_fetch.sv
mips_reg_file.sv
mips_decode.sv
mips_forwarding.sv
mips_execute.sv
mips_data_mem.sv
mips_core.sv
tb_clock_gen.sv
tb_mips_properties.sv
tb_mips.sv

/* tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    input  wire  i_hold,
    output logic o_clk,
    output logic o_rst
);

    int rst_cnt;

    initial begin
        o_clk   = 1'b0;
        o_rst   = 1'b0;
        rst_cnt = 0;
    end

    // 20 ns period
    always #10 o_clk = ~o_clk;

    // Reset low while held, then 8 more cycles before release
    always @(posedge o_clk) begin
        if (i_hold) begin
            rst_cnt <= 0;
            o_rst   <= 1'b0;
        end else if (rst_cnt < 8) begin
            rst_cnt <= rst_cnt + 1;
            o_rst   <= 1'b0;
        end else begin
            o_rst   <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* tb_mips.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mips;

    localparam int IMEM_DEPTH = 256;
    localparam int DMEM_DEPTH = 256;
    localparam int VEC_DEPTH  = 128;
    localparam int TIMEOUT    = 50;

    logic                  clk;
    logic                  rst;
    logic                  hold;
    logic                  load_en;
    logic [7:0]            load_addr;
    logic [31:0]           load_instr;
    logic                  wb_valid;
    logic [4:0]            wb_reg;
    logic [31:0]           wb_data;

    logic [31:0]           vec [VEC_DEPTH];

    tb_clock_gen clk_gen_i (
        .i_hold (hold),
        .o_clk  (clk),
        .o_rst  (rst)
    );

    mips_core #(
        .IMEM_DEPTH (IMEM_DEPTH),
        .DMEM_DEPTH (DMEM_DEPTH)
    ) dut_i (
        .i_clk        (clk),
        .i_rst        (rst),
        .i_load_en    (load_en),
        .i_load_addr  (load_addr),
        .i_load_instr (load_instr),
        .o_wb_valid   (wb_valid),
        .o_wb_reg     (wb_reg),
        .o_wb_data    (wb_data)
    );

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------
    task automatic stop_on_error();
        $display("sim failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
            stop_on_error();
        end
    endtask

    // Sampled on the falling edge, away from the NBA updates
    task automatic wait_for_write(input int idx, output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles = cycles + 1;
        end while (!wb_valid && cycles < TIMEOUT);
        if (!wb_valid) begin
            $display("Timeout: expected register write %0d never showed on the trace", idx);
            stop_on_error();
        end
    endtask

    // ------------------------------------------------------------
    // Load, run and check
    // ------------------------------------------------------------
    initial begin
        int prog_len;
        int exp_count;
        int base;
        int cycles;
        int rst_wait;

        hold       = 1'b1;
        load_en    = 1'b0;
        load_addr  = '0;
        load_instr = '0;
        for (int i = 0; i < VEC_DEPTH; i++) begin
            vec[i] = '0;
        end
        $readmemh("mips_vectors.txt", vec);

        prog_len  = int'(vec[0]);
        base      = prog_len + 1;
        if (prog_len < 1 || base + 1 >= VEC_DEPTH) begin
            $display("Vectors file gives a bad program length %0d", prog_len);
            stop_on_error();
        end
        exp_count = int'(vec[base]);
        if (exp_count < 1 || base + 2 * exp_count >= VEC_DEPTH) begin
            $display("Vectors file gives a bad expected write count %0d", exp_count);
            stop_on_error();
        end

        // Program load, one word per cycle while the core is in reset
        for (int i = 0; i < prog_len; i++) begin
            @(posedge clk);
            load_en    <= 1'b1;
            load_addr  <= 8'(i);
            load_instr <= vec[i + 1];
        end
        @(posedge clk);
        load_en <= 1'b0;
        hold    <= 1'b0;

        rst_wait = 0;
        while (!rst && rst_wait < TIMEOUT) begin
            @(negedge clk);
            rst_wait = rst_wait + 1;
        end
        if (!rst) begin
            $display("Timeout: reset was never released");
            stop_on_error();
        end

        // Fetch edge of word 0
        @(posedge clk);

        for (int n = 0; n < exp_count; n++) begin
            wait_for_write(n, cycles);
            if (n == 0) begin
                compare("first_write_latency", 32'(cycles), 32'd4);
            end
            compare("o_wb_reg", 32'(wb_reg), vec[base + 1 + 2 * n]);
            compare("o_wb_data", wb_data, vec[base + 2 + 2 * n]);
        end

        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

/* tb_mips_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mips_properties (
    input wire       i_clk,
    input wire       i_rst,
    input wire       i_load_en,
    input wire       i_dec_reg_write,
    input wire [4:0] i_dec_dest,
    input wire       o_wb_valid,
    input wire [4:0] o_wb_reg
);

    // Trace stays quiet once reset has been seen for a cycle
    a_no_trace_in_reset: assert property (@(posedge i_clk)
        ($past(!i_rst) && !i_rst) |-> !o_wb_valid)
        else $error("retire trace active during reset");

    // A write decoded with r0 as target never reaches the trace three edges later
    a_no_r0_trace: assert property (@(posedge i_clk)
        $past(i_dec_reg_write && (i_dec_dest == 5'd0), 3) |-> !o_wb_valid)
        else $error("retire trace reports a write to register zero");

    // Trace register is the destination decoded three edges earlier
    a_trace_reg_from_decode: assert property (@(posedge i_clk)
        o_wb_valid |-> (o_wb_reg == $past(i_dec_dest, 3)))
        else $error("retire trace register differs from the decoded destination");

    a_load_only_in_reset: assert property (@(posedge i_clk)
        i_rst |-> !i_load_en)
        else $error("program load port used outside reset");

endmodule

bind mips_core tb_mips_properties props_i (
    .i_clk           (i_clk),
    .i_rst           (i_rst),
    .i_load_en       (i_load_en),
    .i_dec_reg_write (dec_reg_write),
    .i_dec_dest      (dec_dest),
    .o_wb_valid      (o_wb_valid),
    .o_wb_reg        (o_wb_reg)
);

`default_nettype wire
